// File: hdl/motor_pkg.sv
// Motor package
// Widths, FSM state codes, motion thresholds, the hammer startup table and
// the profile word shared by the angle to PWM controller
package motor_pkg;

    localparam int ANGLE_W    = 12;        // Encoder angle width
    localparam int ANGLE_FULL = 4096;      // Points per rotation
    localparam int STEP_W     = 4;         // Profile step index width
    localparam int NUM_STEPS  = 16;
    localparam logic [STEP_W-1:0] LAST_STEP = 4'd15;
    localparam int RATIO_W    = 8;         // PWM high time out of 255
    localparam int STATE_W    = 4;

    // FSM state codes
    localparam logic [STATE_W-1:0] ST_IDLE        = 4'd0;
    localparam logic [STATE_W-1:0] ST_CALC        = 4'd1;
    localparam logic [STATE_W-1:0] ST_ACCEL       = 4'd2;
    localparam logic [STATE_W-1:0] ST_HAMMER_FWD  = 4'd3;
    localparam logic [STATE_W-1:0] ST_HAMMER_RVS  = 4'd4;
    localparam logic [STATE_W-1:0] ST_HAMMER_PASS = 4'd5;
    localparam logic [STATE_W-1:0] ST_HAMMER_FAIL = 4'd6;
    localparam logic [STATE_W-1:0] ST_CRUISE      = 4'd7;
    localparam logic [STATE_W-1:0] ST_DECEL       = 4'd8;
    localparam logic [STATE_W-1:0] ST_SHUTDOWN    = 4'd9;

    localparam logic [ANGLE_W-1:0] TARGET_TOLERANCE = 12'd5;  // Move is complete below this
    localparam logic [ANGLE_W-1:0] DECEL_DISTANCE   = 12'd40; // Leave cruise below this
    localparam logic [ANGLE_W-1:0] MOVE_THRESHOLD   = 12'd3;  // Min change counted as movement

    // Ratio source selects
    localparam logic [2:0] RS_ZERO   = 3'd0;
    localparam logic [2:0] RS_LINEAR = 3'd1;
    localparam logic [2:0] RS_HAMMER = 3'd2;
    localparam logic [2:0] RS_CRUISE = 3'd3;

    // Hammer ratios before the offset, step 15 first down to step 0
    localparam logic [NUM_STEPS-1:0][RATIO_W-1:0] HAMMER_TABLE = {
        8'd0,  8'd80, 8'd40, 8'd100, 8'd40, 8'd80, 8'd40, 8'd100,
        8'd40, 8'd80, 8'd40, 8'd60,  8'd40, 8'd100, 8'd80, 8'd40
    };

    // Linear profile, flat at the port and byte steps in the ratio mux
    typedef union packed {
        logic [NUM_STEPS*RATIO_W-1:0]           flat;
        logic [NUM_STEPS-1:0][RATIO_W-1:0]      step;
    } profile_word_u;

endpackage

// File: hdl/angle_delta.sv
// Angle delta
// Registered shortest path distance and direction from the encoder angle
// to the target angle, with wraparound at the end of the turn
module angle_delta (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [motor_pkg::ANGLE_W-1:0] target_angle,
    input  logic [motor_pkg::ANGLE_W-1:0] current_angle,
    output logic [motor_pkg::ANGLE_W-1:0] delta_angle,
    output logic                         dir_shortest   // 1 when increasing angle is shorter
);

    logic [motor_pkg::ANGLE_W-1:0] abs_diff;
    logic                          target_above;   // Target sits above encoder on the raw scale
    logic                          wrap;           // Shorter path crosses zero

    assign target_above = (target_angle >= current_angle);
    assign abs_diff     = target_above ? (target_angle - current_angle)
                                       : (current_angle - target_angle);
    assign wrap         = (abs_diff > motor_pkg::ANGLE_W'(motor_pkg::ANGLE_FULL / 2));

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            delta_angle  <= '0;
            dir_shortest <= 1'b1;
        end else begin
            if (wrap) begin
                delta_angle  <= motor_pkg::ANGLE_W'(motor_pkg::ANGLE_FULL - abs_diff);
                dir_shortest <= ~target_above;  // Going the other way round is shorter
            end else begin
                delta_angle  <= abs_diff;
                // Half a turn exactly is a tie, taken as increasing
                dir_shortest <= target_above |
                                (abs_diff == motor_pkg::ANGLE_W'(motor_pkg::ANGLE_FULL / 2));
            end
        end
    end

endmodule

// File: hdl/dwell_timer.sv
// Dwell timer
// Detects absorbed PWM updates on the rising edge of pwm_done, holds each
// profile step for delay_target+1 of them and walks the step index
module dwell_timer (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          pwm_done,
    input  logic [motor_pkg::RATIO_W-1:0] delay_target,
    input  logic                          step_run,       // Count absorbed updates
    input  logic                          step_down,      // Tick walks the step down
    input  logic                          step_load_last, // Jump to the last step
    input  logic                          step_clear,     // Zero step and dwell count
    output logic                          step_tick,
    output logic [motor_pkg::STEP_W-1:0]  curr_step
);

    logic                          done_q;
    logic                          done_edge;   // Registered rising edge of pwm_done
    logic [motor_pkg::RATIO_W-1:0] dwell_cnt;

    // Last edge of the dwell while running
    assign step_tick = step_run & done_edge & (dwell_cnt == delay_target);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            done_q    <= 1'b0;
            done_edge <= 1'b0;
            dwell_cnt <= '0;
            curr_step <= '0;
        end else begin
            done_q    <= pwm_done;
            done_edge <= pwm_done & ~done_q;  // Only a fresh done counts as absorbed
            if (step_clear) begin
                dwell_cnt <= '0;
                curr_step <= '0;
            end else if (step_load_last) begin
                dwell_cnt <= '0;
                curr_step <= motor_pkg::LAST_STEP;
            end else if (step_tick) begin
                dwell_cnt <= '0;
                if (!step_down)
                    curr_step <= curr_step + 1'b1;
                else if (curr_step != '0)
                    curr_step <= curr_step - 1'b1;  // Hold at step 0 on the way down
            end else if (step_run && done_edge) begin
                dwell_cnt <= dwell_cnt + 1'b1;
            end
        end
    end

    // FSM loads the last step only out of cruise, never while clearing
    assert property (@(posedge clock) disable iff (!reset_n)
        !(step_load_last && step_clear));

endmodule

// File: hdl/hammer_monitor.sv
// Hammer monitor
// Samples the encoder on every hammer step, counts real movement and
// retries, and flags pass or fail of the hammer startup
module hammer_monitor (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic [motor_pkg::STATE_W-1:0] state,
    input  logic                          step_tick,
    input  logic [motor_pkg::STEP_W-1:0]  curr_step,
    input  logic [motor_pkg::ANGLE_W-1:0] current_angle,
    input  logic [3:0]                    fwd_count,
    input  logic [3:0]                    rvs_count,
    input  logic [1:0]                    retry_count,
    input  logic [2:0]                    consec_chg,
    output logic                          fwd_end,
    output logic                          rvs_end,
    output logic                          hammer_pass,
    output logic                          hammer_fail
);

    logic [motor_pkg::ANGLE_W-1:0] sample_angle;  // Encoder at the previous tick
    logic [motor_pkg::ANGLE_W-1:0] move_up, move_dn, move_abs;
    logic [2:0]                    chg_cnt;
    logic [1:0]                    retry_cnt;
    logic                          in_hammer;

    assign in_hammer = (state == motor_pkg::ST_HAMMER_FWD) |
                       (state == motor_pkg::ST_HAMMER_RVS);

    // Both directions wrap the same way, take the shorter one
    assign move_up  = current_angle - sample_angle;
    assign move_dn  = sample_angle - current_angle;
    assign move_abs = (move_up < move_dn) ? move_up : move_dn;

    assign fwd_end = (state == motor_pkg::ST_HAMMER_FWD) & step_tick & (curr_step == fwd_count);
    assign rvs_end = (state == motor_pkg::ST_HAMMER_RVS) & step_tick & (curr_step == rvs_count);

    assign hammer_pass = (chg_cnt == consec_chg);
    assign hammer_fail = (retry_cnt == retry_count);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            sample_angle <= '0;
            chg_cnt      <= '0;
            retry_cnt    <= '0;
        end else if (state == motor_pkg::ST_CALC) begin
            sample_angle <= current_angle;  // Fresh start for a new move
            chg_cnt      <= '0;
            retry_cnt    <= '0;
        end else if (in_hammer && step_tick) begin
            sample_angle <= current_angle;
            if (move_abs >= motor_pkg::MOVE_THRESHOLD)
                chg_cnt <= chg_cnt + 1'b1;
            if (fwd_end)
                retry_cnt <= retry_cnt + 1'b1;  // One forward pass done
        end
    end

    // A forward end always takes the FSM out of the forward state
    assert property (@(posedge clock) disable iff (!reset_n)
        fwd_end |=> (state != motor_pkg::ST_HAMMER_FWD));

endmodule

// File: hdl/drive_ratio.sv
// Drive ratio
// Picks the PWM ratio for the current phase and step, and the motor
// direction, both registered toward the PWM block
module drive_ratio (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic [2:0]                    ratio_sel,
    input  logic [motor_pkg::STEP_W-1:0]  curr_step,
    input  logic                          reverse,        // Hammer reverse phase
    input  logic                          dir_shortest,
    input  motor_pkg::profile_word_u      pwm_profile,
    input  logic [motor_pkg::RATIO_W-1:0] profile_offset,
    input  logic [motor_pkg::RATIO_W-1:0] cruise_power,
    output logic [motor_pkg::RATIO_W-1:0] pwm_ratio,
    output logic                          pwm_direction
);

    logic [motor_pkg::RATIO_W-1:0] ratio_next;

    always_comb begin
        case (ratio_sel)
            // Offset sums wrap modulo 256
            motor_pkg::RS_LINEAR: ratio_next = pwm_profile.step[curr_step] + profile_offset;
            motor_pkg::RS_HAMMER:
                ratio_next = motor_pkg::HAMMER_TABLE[curr_step] + profile_offset;
            motor_pkg::RS_CRUISE: ratio_next = cruise_power;
            default:              ratio_next = '0;  // Idle, fail and shutdown
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pwm_ratio     <= '0;
            pwm_direction <= 1'b0;
        end else begin
            pwm_ratio     <= ratio_next;
            pwm_direction <= dir_shortest ^ reverse;  // Reverse hammer pushes the other way
        end
    end

endmodule

// File: hdl/motion_fsm.sv
// Motion FSM
// Sequences calculate, accelerate or hammer startup, cruise, decelerate
// and shutdown, and drives the step controls and PWM handshake
module motion_fsm (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          angle_update,
    input  logic                          abort_angle,
    input  logic                          enable_hammer,
    input  logic [motor_pkg::ANGLE_W-1:0] delta_angle,
    input  logic                          step_tick,
    input  logic [motor_pkg::STEP_W-1:0]  curr_step,
    input  logic                          fwd_end,
    input  logic                          rvs_end,
    input  logic                          hammer_pass,
    input  logic                          hammer_fail,
    output logic [motor_pkg::STATE_W-1:0] state,
    output logic                          step_run,
    output logic                          step_down,
    output logic                          step_load_last,
    output logic                          step_clear,
    output logic [2:0]                    ratio_sel,
    output logic                          reverse,
    output logic                          pwm_update,
    output logic                          angle_done,
    output logic                          startup_fail
);

    logic [motor_pkg::STATE_W-1:0] next_state;

    always_comb begin
        next_state = state;
        case (state)
            motor_pkg::ST_IDLE: if (angle_update) next_state = motor_pkg::ST_CALC;
            motor_pkg::ST_CALC: begin  // One cycle only
                if (abort_angle || delta_angle <= motor_pkg::TARGET_TOLERANCE)
                    next_state = motor_pkg::ST_IDLE;
                else if (enable_hammer)
                    next_state = motor_pkg::ST_HAMMER_FWD;
                else
                    next_state = motor_pkg::ST_ACCEL;
            end
            motor_pkg::ST_ACCEL: begin
                if (abort_angle)
                    next_state = motor_pkg::ST_DECEL;  // Ramp down from the current step
                else if (step_tick && curr_step == motor_pkg::LAST_STEP)
                    next_state = motor_pkg::ST_CRUISE;
            end
            motor_pkg::ST_HAMMER_FWD: begin
                if (hammer_fail)      next_state = motor_pkg::ST_HAMMER_FAIL;
                else if (hammer_pass) next_state = motor_pkg::ST_HAMMER_PASS;
                else if (fwd_end)     next_state = motor_pkg::ST_HAMMER_RVS;
            end
            motor_pkg::ST_HAMMER_RVS:  if (rvs_end) next_state = motor_pkg::ST_HAMMER_FWD;
            motor_pkg::ST_HAMMER_PASS: next_state = motor_pkg::ST_CRUISE;
            motor_pkg::ST_HAMMER_FAIL: if (angle_update) next_state = motor_pkg::ST_CALC;
            motor_pkg::ST_CRUISE:
                if (abort_angle || delta_angle < motor_pkg::DECEL_DISTANCE)
                    next_state = motor_pkg::ST_DECEL;
            motor_pkg::ST_DECEL:
                if (delta_angle < motor_pkg::TARGET_TOLERANCE) next_state = motor_pkg::ST_SHUTDOWN;
            motor_pkg::ST_SHUTDOWN: if (step_tick) next_state = motor_pkg::ST_IDLE;
            default: next_state = motor_pkg::ST_IDLE;
        endcase
    end

    // Dwell is counted in every profile phase and in shutdown, not in cruise
    assign step_run = (state == motor_pkg::ST_ACCEL) | (state == motor_pkg::ST_HAMMER_FWD) |
                      (state == motor_pkg::ST_HAMMER_RVS) | (state == motor_pkg::ST_DECEL) |
                      (state == motor_pkg::ST_SHUTDOWN);
    assign step_down      = (state == motor_pkg::ST_DECEL);
    assign step_load_last = (state == motor_pkg::ST_CRUISE) & (next_state == motor_pkg::ST_DECEL);
    assign step_clear = (state == motor_pkg::ST_IDLE) | (state == motor_pkg::ST_CALC) |
                        (state == motor_pkg::ST_HAMMER_FWD && next_state != state) |
                        (state == motor_pkg::ST_HAMMER_RVS && next_state != state) |
                        (state == motor_pkg::ST_DECEL && next_state != state);
    assign reverse = (state == motor_pkg::ST_HAMMER_RVS);

    always_comb begin
        case (state)
            motor_pkg::ST_ACCEL, motor_pkg::ST_DECEL:           ratio_sel = motor_pkg::RS_LINEAR;
            motor_pkg::ST_HAMMER_FWD, motor_pkg::ST_HAMMER_RVS: ratio_sel = motor_pkg::RS_HAMMER;
            motor_pkg::ST_HAMMER_PASS, motor_pkg::ST_CRUISE:    ratio_sel = motor_pkg::RS_CRUISE;
            default:                                            ratio_sel = motor_pkg::RS_ZERO;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state        <= motor_pkg::ST_IDLE;
            pwm_update   <= 1'b0;
            angle_done   <= 1'b0;
            startup_fail <= 1'b0;
        end else begin
            state <= next_state;
            // Level from leaving calculate until idle or startup failure
            pwm_update <= (next_state != motor_pkg::ST_IDLE) &
                          (next_state != motor_pkg::ST_CALC) &
                          (next_state != motor_pkg::ST_HAMMER_FAIL);
            angle_done <= (state == motor_pkg::ST_SHUTDOWN) & (next_state == motor_pkg::ST_IDLE);
            if (state == motor_pkg::ST_CALC)
                startup_fail <= 1'b0;
            else if (state == motor_pkg::ST_HAMMER_FAIL)
                startup_fail <= 1'b1;  // Held until the next move request
        end
    end

    // Done pulse lasts one clock, idle always follows shutdown
    assert property (@(posedge clock) disable iff (!reset_n) angle_done |=> !angle_done);

endmodule

// File: hdl/angle_to_pwm.sv
// Angle to PWM controller
// Drives a brushed wheel motor from the encoder angle to a target angle
// through linear or hammer acceleration, cruise and deceleration
module angle_to_pwm (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic [motor_pkg::ANGLE_W-1:0] target_angle,   // 4096 points per turn
    input  logic [motor_pkg::ANGLE_W-1:0] current_angle,  // From the encoder
    input  logic                          angle_update,   // Start a move
    input  logic                          abort_angle,
    input  logic                          pwm_done,       // Ratio absorbed by the PWM
    input  logic                          enable_hammer,  // Hammer startup instead of linear
    input  logic [3:0]                    fwd_count,
    input  logic [3:0]                    rvs_count,
    input  logic [1:0]                    retry_count,
    input  logic [2:0]                    consec_chg,     // Moves needed to pass startup
    input  logic [motor_pkg::RATIO_W-1:0] delay_target,   // Absorbed updates per step, minus 1
    input  logic [motor_pkg::RATIO_W-1:0] profile_offset,
    input  logic [motor_pkg::RATIO_W-1:0] cruise_power,
    input  logic [127:0]                  pwm_profile,    // 16 byte steps, step 0 in the low byte
    output logic                          startup_fail,
    output logic                          angle_done,
    output logic                          pwm_enable,
    output logic                          pwm_update,
    output logic                          pwm_direction,
    output logic [motor_pkg::RATIO_W-1:0] pwm_ratio
);

    logic [motor_pkg::ANGLE_W-1:0] delta_angle;
    logic                          dir_shortest;
    logic [motor_pkg::STATE_W-1:0] state;
    logic [motor_pkg::STEP_W-1:0]  curr_step;
    logic                          step_tick, step_run, step_down, step_load_last, step_clear;
    logic [2:0]                    ratio_sel;
    logic                          reverse;
    logic                          fwd_end, rvs_end, hammer_pass, hammer_fail;
    motor_pkg::profile_word_u      profile_word;

    assign pwm_enable        = 1'b1;
    assign profile_word.flat = pwm_profile;

    motion_fsm i_motion_fsm (
        .clock, .reset_n, .angle_update, .abort_angle, .enable_hammer, .delta_angle,
        .step_tick, .curr_step, .fwd_end, .rvs_end, .hammer_pass, .hammer_fail,
        .state, .step_run, .step_down, .step_load_last, .step_clear, .ratio_sel,
        .reverse, .pwm_update, .angle_done, .startup_fail
    );

    dwell_timer i_dwell_timer (
        .clock, .reset_n, .pwm_done, .delay_target, .step_run, .step_down,
        .step_load_last, .step_clear, .step_tick, .curr_step
    );

    angle_delta i_angle_delta (
        .clock, .reset_n, .target_angle, .current_angle, .delta_angle, .dir_shortest
    );

    hammer_monitor i_hammer_monitor (
        .clock, .reset_n, .state, .step_tick, .curr_step, .current_angle,
        .fwd_count, .rvs_count, .retry_count, .consec_chg,
        .fwd_end, .rvs_end, .hammer_pass, .hammer_fail
    );

    drive_ratio i_drive_ratio (
        .clock, .reset_n, .ratio_sel, .curr_step, .reverse, .dir_shortest,
        .pwm_profile (profile_word),
        .profile_offset, .cruise_power, .pwm_ratio, .pwm_direction
    );

endmodule

// File: verif/tb_angle_to_pwm.sv
// Angle to PWM testbench
// Directed tests against a PWM responder that absorbs ratios and logs each
// new direction and ratio pair
module tb_angle_to_pwm;

    logic                          clock, reset_n;
    logic [motor_pkg::ANGLE_W-1:0] target_angle, current_angle;
    logic                          angle_update, abort_angle, pwm_done, enable_hammer;
    logic [3:0]                    fwd_count, rvs_count;
    logic [1:0]                    retry_count;
    logic [2:0]                    consec_chg;
    logic [motor_pkg::RATIO_W-1:0] delay_target, profile_offset, cruise_power;
    logic [127:0]                  pwm_profile;
    logic                          startup_fail, angle_done, pwm_enable, pwm_update;
    logic                          pwm_direction;
    logic [motor_pkg::RATIO_W-1:0] pwm_ratio;

    logic [7:0] prof [16];              // Random profile bytes
    logic [8:0] ratio_log [$];          // {direction, ratio} on every change
    logic [8:0] expect_log [$];
    logic [8:0] last_word, expect_last;
    logic       advance;                // Encoder moves 10 points per done pulse
    int         done_count, test_err, tests_ok, tests_bad;

    angle_to_pwm i_angle_to_pwm (
        .clock, .reset_n, .target_angle, .current_angle, .angle_update, .abort_angle,
        .pwm_done, .enable_hammer, .fwd_count, .rvs_count, .retry_count, .consec_chg,
        .delay_target, .profile_offset, .cruise_power, .pwm_profile, .startup_fail,
        .angle_done, .pwm_enable, .pwm_update, .pwm_direction, .pwm_ratio
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // PWM block model pulsing done one cycle in four while updates run
    initial begin : responder
        logic [1:0] phase;
        phase    = '0;
        pwm_done = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (pwm_update) begin
                phase    = phase + 1'b1;
                pwm_done = (phase == 2'd0);
                if (pwm_done && advance)
                    current_angle = current_angle + 12'd10;
            end else begin
                phase    = '0;
                pwm_done = 1'b0;
            end
        end
    end

    always @(negedge clock) begin  // Outputs settled mid cycle
        if ({pwm_direction, pwm_ratio} !== last_word) begin
            ratio_log.push_back({pwm_direction, pwm_ratio});
            last_word = {pwm_direction, pwm_ratio};
        end
        if (angle_done)
            done_count++;
    end

    // Increasing direction wins when its distance is at most half a turn
    function automatic logic dir_of(input logic [11:0] target, input logic [11:0] enc);
        logic [11:0] up;
        up = target - enc;
        return (up <= 12'd2048);
    endfunction

    function automatic logic [7:0] ham_base(input int k);
        case (k)
            0, 3, 5, 7, 9, 11, 13: return 8'd40;
            1, 6, 10, 14:          return 8'd80;
            2, 8, 12:              return 8'd100;
            4:                     return 8'd60;
            default:               return 8'd0;
        endcase
    endfunction

    task automatic push_expect(input logic dir, input logic [7:0] ratio);
        if ({dir, ratio} !== expect_last) begin  // Same pair twice is one log entry
            expect_log.push_back({dir, ratio});
            expect_last = {dir, ratio};
        end
    endtask

    task automatic push_linear(input logic dir, input int from, input int to);
        int k;
        k = from;
        push_expect(dir, prof[k] + profile_offset);
        while (k != to) begin
            k = (to > from) ? k + 1 : k - 1;
            push_expect(dir, prof[k] + profile_offset);
        end
    endtask

    task automatic push_hammer(input logic dir, input int last);
        for (int k = 0; k <= last; k++)
            push_expect(dir, ham_base(k) + profile_offset);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            test_err++;
        end
    endtask

    task automatic wait_log(input int n);
        int cycles;
        cycles = 0;
        while (ratio_log.size() < n && cycles < 2000) begin
            @(negedge clock);
            #1;
            cycles++;
        end
        if (ratio_log.size() < n) begin
            $display("ratio log stuck at %0d entries, waited for %0d", ratio_log.size(), n);
            test_err++;
        end
    endtask

    task automatic compare_log();
        int i;
        if (ratio_log.size() != expect_log.size()) begin
            $display("ratio log has %0d entries, %0d expected", ratio_log.size(),
                     expect_log.size());
            test_err++;
        end
        for (i = 0; i < expect_log.size() && i < ratio_log.size(); i++)
            if (ratio_log[i] !== expect_log[i]) begin
                $display("error pwm_direction,pwm_ratio [%0d]: got %h expected %h", i,
                         ratio_log[i], expect_log[i]);
                test_err++;
            end
    endtask

    // Set angles, let the delta settle, clear logs and request the move
    task automatic start_move(input logic [11:0] target, input logic [11:0] enc,
                              input logic hammer);
        target_angle  = target;
        current_angle = enc;
        enable_hammer = hammer;
        repeat (3) @(posedge clock);
        #1;
        ratio_log.delete();
        expect_log.delete();
        expect_last  = last_word;
        done_count   = 0;
        angle_update = 1'b1;
        @(posedge clock);
        #1;
        angle_update = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done_count == 0 && cycles < 2000) begin
            @(negedge clock);
            #1;
            cycles++;
        end
        if (done_count == 0) begin
            $display("angle_done never pulsed");
            test_err++;
        end
        repeat (20) @(negedge clock);
        #1;
        check_val("angle_done pulse count", done_count, 1);
        check_val("pwm_ratio", pwm_ratio, 0);
        check_val("pwm_update", pwm_update, 0);
        @(posedge clock);
        #1;
    endtask

    task automatic finish_test(input string name);
        if (test_err == 0) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, test_err);
            tests_bad++;
        end
        test_err = 0;
    endtask

    task automatic reset_values();
        check_val("pwm_ratio", pwm_ratio, 0);
        check_val("pwm_update", pwm_update, 0);
        check_val("angle_done", angle_done, 0);
        check_val("startup_fail", startup_fail, 0);
        check_val("pwm_enable", pwm_enable, 1);
        finish_test("reset values");
    endtask

    task automatic within_tolerance();
        int bad;
        start_move(12'd104, 12'd100, 1'b0);
        bad = 0;
        repeat (50) begin
            @(negedge clock);
            if (pwm_update || angle_done)
                bad++;
        end
        if (bad != 0) begin
            $display("pwm_update or angle_done high on %0d cycles of a 4 point move", bad);
            test_err++;
        end
        @(posedge clock);
        #1;
        finish_test("move within tolerance");
    endtask

    task automatic linear_across_zero();
        logic d;
        d = dir_of(12'd4090, 12'd20);  // Decreasing across zero
        start_move(12'd4090, 12'd20, 1'b0);
        push_linear(d, 0, 15);
        push_expect(d, cruise_power);
        wait_log(expect_log.size());
        check_val("pwm_direction", pwm_direction, d);
        @(posedge clock);
        #1;
        current_angle = 12'd24;      // 30 points short on the same side
        push_linear(d, 15, 0);
        wait_log(expect_log.size());
        @(posedge clock);
        #1;
        current_angle = 12'd4092;    // 2 points away
        push_expect(d, 8'd0);
        wait_done();
        compare_log();
        finish_test("linear move across zero");
    endtask

    task automatic abort_in_accel();
        logic d;
        d = dir_of(12'd2000, 12'd1000);
        start_move(12'd2000, 12'd1000, 1'b0);
        push_linear(d, 0, 3);
        wait_log(expect_log.size());
        @(posedge clock);
        #1;
        abort_angle = 1'b1;
        @(posedge clock);
        #1;
        abort_angle = 1'b0;
        push_linear(d, 2, 0);        // Ramp down from step 3
        wait_log(expect_log.size());
        @(posedge clock);
        #1;
        current_angle = 12'd2000;
        push_expect(d, 8'd0);
        wait_done();
        compare_log();
        finish_test("abort during acceleration");
    endtask

    task automatic hammer_frozen();
        logic d;
        int   cycles;
        retry_count = 2'd2;
        fwd_count   = 4'd3;
        rvs_count   = 4'd2;
        consec_chg  = 3'd3;
        d = dir_of(12'd700, 12'd200);
        start_move(12'd700, 12'd200, 1'b1);
        repeat (retry_count) begin
            push_hammer(d, fwd_count);
            push_hammer(~d, rvs_count);  // Reverse pushes the other way
        end
        push_hammer(d, 0);               // Failure seen on entering forward
        push_expect(d, 8'd0);
        cycles = 0;
        while (!startup_fail && cycles < 2000) begin
            @(negedge clock);
            cycles++;
        end
        if (!startup_fail) begin
            $display("startup_fail never rose with the encoder frozen");
            test_err++;
        end
        repeat (3) @(negedge clock);
        #1;
        check_val("startup_fail", startup_fail, 1);
        check_val("pwm_ratio", pwm_ratio, 0);
        check_val("pwm_update", pwm_update, 0);
        compare_log();
        @(posedge clock);
        #1;
        finish_test("hammer failure");
    endtask

    task automatic hammer_moving();
        logic d;
        retry_count = 2'd2;
        fwd_count   = 4'd3;
        rvs_count   = 4'd2;
        consec_chg  = 3'd2;
        advance     = 1'b1;
        d = dir_of(12'd1000, 12'd100);
        start_move(12'd1000, 12'd100, 1'b1);
        push_hammer(d, consec_chg);      // One step per counted move and one more
        push_expect(d, cruise_power);
        wait_log(expect_log.size());
        check_val("startup_fail", startup_fail, 0);
        repeat (40) @(posedge clock);    // Cruise holds while the target is far
        #1;
        advance       = 1'b0;
        current_angle = 12'd1000;
        push_expect(d, prof[15] + profile_offset);  // Decel starts at the last step
        push_expect(d, 8'd0);
        wait_done();
        compare_log();
        finish_test("hammer pass");
    endtask

    initial begin : main
        void'($urandom(87630));
        reset_n        = 1'b0;
        target_angle   = '0;
        current_angle  = '0;
        angle_update   = 1'b0;
        abort_angle    = 1'b0;
        enable_hammer  = 1'b0;
        fwd_count      = 4'd3;
        rvs_count      = 4'd2;
        retry_count    = 2'd1;
        consec_chg     = 3'd7;
        delay_target   = 8'd1;           // Two absorbed updates per step
        cruise_power   = 8'hc8;
        advance        = 1'b0;
        last_word      = '0;
        expect_last    = '0;
        done_count     = 0;
        test_err       = 0;
        tests_ok       = 0;
        tests_bad      = 0;
        profile_offset = 8'($urandom);
        for (int k = 0; k < 16; k++) begin
            prof[k] = 8'($urandom);
            while (k > 0 && prof[k] == prof[k-1])  // Neighbours differ
                prof[k] = 8'($urandom);
            pwm_profile[k*8 +: 8] = prof[k];
        end
        repeat (10) @(posedge clock);
        #1;
        reset_n = 1'b1;
        reset_values();
        within_tolerance();
        linear_across_zero();
        abort_in_accel();
        hammer_frozen();
        hammer_moving();
        $display("%0d tests passed, %0d tests failed", tests_ok, tests_bad);
        if (tests_bad == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(6 * 20000);
        $display("run did not finish within %0d time units", 6 * 20000);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: files.f
hdl/motor_pkg.sv
hdl/angle_delta.sv
hdl/dwell_timer.sv
hdl/hammer_monitor.sv
hdl/drive_ratio.sv
hdl/motion_fsm.sv
hdl/angle_to_pwm.sv
verif/tb_angle_to_pwm.sv
